//--- rtl/soc_params.svh
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// I/O port map, byte addresses on the data bus
`define LEDS_PORT       16'hfffe
`define BIOS_CTRL_PORT  16'hffec
`define TIMER_PORT      16'hffee
`define IRQ_PORT_BASE   16'hfff4   // Mask at +0, pending/vector at +2

// Upper six address bits of the BIOS shadow window (FC000-FFFFF)
`define BIOS_BASE       6'b111111

// RAM depths in 16-bit words
`define MAIN_RAM_WORDS  4096
`define BIOS_RAM_WORDS  8192

`define NUM_LEDS        8

// Clocks per timer tick
`define TIMER_PRESCALE  4

`endif

//--- rtl/soc_pkg.sv
package soc_pkg;

    // One bus request, held by the master until ack
    typedef struct packed {
        logic [19:1] addr;      // Word address
        logic [15:0] wdata;
        logic        wr_en;
        logic [1:0]  bytesel;   // Bit 1 high byte, bit 0 low byte
        logic        access;
    } bus_req_t;

    // One bus response, zero outside the ack cycle
    typedef struct packed {
        logic [15:0] rdata;
        logic        ack;
    } bus_rsp_t;

    // Peripheral selects from the I/O decode
    typedef struct packed {
        logic leds;
        logic bios_ctrl;
        logic timer;
        logic irq;
        logic dflt;             // Unmapped port
    } io_sel_t;

endpackage

//--- rtl/mem_arbiter.sv
module mem_arbiter import soc_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  bus_req_t data_req,
    input  bus_req_t instr_req,
    input  bus_rsp_t q_rsp,
    output bus_req_t q_req,
    output bus_rsp_t data_mem_rsp,
    output bus_rsp_t instr_rsp
);

    typedef enum logic [1:0] {
        GRANT_IDLE,
        GRANT_DATA,
        GRANT_INSTR
    } grant_t;

    grant_t grant;

    // A new grant is only taken from idle, so the master that was just
    // acked has dropped access before anyone is granted again
    always_ff @(posedge clk) begin
        if (rst) begin
            grant <= GRANT_IDLE;
        end else begin
            case (grant)
                GRANT_IDLE: begin
                    if (data_req.access) begin
                        grant <= GRANT_DATA;    // Data wins a tie
                    end else if (instr_req.access) begin
                        grant <= GRANT_INSTR;
                    end
                end
                default: begin
                    if (q_rsp.ack) begin
                        grant <= GRANT_IDLE;
                    end
                end
            endcase
        end
    end

    always_comb begin
        case (grant)
            GRANT_DATA: begin
                q_req = data_req;
            end
            GRANT_INSTR: begin
                q_req       = instr_req;
                q_req.wr_en = 1'b0;     // Fetches never write
            end
            default: begin
                q_req = '0;
            end
        endcase
    end

    // Steer the shared response back to its owner
    assign data_mem_rsp = (grant == GRANT_DATA) ? q_rsp : '0;
    assign instr_rsp    = (grant == GRANT_INSTR) ? q_rsp : '0;

endmodule

//--- rtl/bus_decoder.sv
`include "soc_params.svh"

module bus_decoder import soc_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  bus_req_t data_req,
    input  logic     d_io,
    input  bus_req_t q_req,
    input  logic     bios_enabled,
    input  bus_rsp_t main_rsp,
    input  bus_rsp_t bios_rsp,
    input  bus_rsp_t periph_rsp [4],
    output io_sel_t  io_sel,
    output logic     main_cs,
    output logic     bios_cs,
    output bus_rsp_t q_rsp,
    output bus_rsp_t io_rsp
);

    localparam logic [15:0] IRQ_BASE = `IRQ_PORT_BASE;

    logic [15:0] port;
    logic        dflt_ack;
    logic        bios_hit;

    assign port = {data_req.addr[15:1], 1'b0};

    always_comb begin
        io_sel = '0;
        if (d_io && data_req.access) begin
            if (port == `LEDS_PORT) begin
                io_sel.leds = 1'b1;
            end else if (port == `BIOS_CTRL_PORT) begin
                io_sel.bios_ctrl = 1'b1;
            end else if (port == `TIMER_PORT) begin
                io_sel.timer = 1'b1;
            end else if (port[15:2] == IRQ_BASE[15:2]) begin
                io_sel.irq = 1'b1;      // Two ports
            end else begin
                io_sel.dflt = 1'b1;
            end
        end
    end

    // Default slave, acks unmapped ports with zero data
    always_ff @(posedge clk) begin
        if (rst) begin
            dflt_ack <= 1'b0;
        end else begin
            dflt_ack <= io_sel.dflt && !dflt_ack;
        end
    end

    always_comb begin
        io_rsp.ack   = dflt_ack;
        io_rsp.rdata = '0;
        for (int i = 0; i < 4; i++) begin
            io_rsp.ack   = io_rsp.ack | periph_rsp[i].ack;
            io_rsp.rdata = io_rsp.rdata | periph_rsp[i].rdata;
        end
    end

    // BIOS shadow only overlays main RAM while enabled
    assign bios_hit = bios_enabled && (q_req.addr[19:14] == `BIOS_BASE);
    assign bios_cs  = q_req.access && bios_hit;
    assign main_cs  = q_req.access && !bios_hit;

    assign q_rsp.rdata = main_rsp.rdata | bios_rsp.rdata;
    assign q_rsp.ack   = main_rsp.ack | bios_rsp.ack;

endmodule

//--- rtl/onchip_ram.sv
module onchip_ram import soc_pkg::*; #(
    parameter int DEPTH = 4096
) (
    input  logic     clk,
    input  logic     rst,
    input  bus_req_t req,
    input  logic     cs,
    output bus_rsp_t rsp
);

    localparam int AW = $clog2(DEPTH);

    logic [15:0]   mem [DEPTH];
    logic [AW-1:0] idx;
    logic [15:0]   rd_q;
    logic          ack;
    logic          hit;

    assign idx = req.addr[AW:1];    // Address modulo DEPTH
    assign hit = cs && req.access && !ack;

    always_ff @(posedge clk) begin
        if (hit && req.wr_en) begin
            if (req.bytesel[0]) begin
                mem[idx][7:0] <= req.wdata[7:0];
            end
            if (req.bytesel[1]) begin
                mem[idx][15:8] <= req.wdata[15:8];
            end
        end
        if (hit) begin
            rd_q <= mem[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
        end else begin
            ack <= hit;     // Once per access
        end
    end

    assign rsp.rdata = ack ? rd_q : '0;
    assign rsp.ack   = ack;

endmodule

//--- rtl/system_registers.sv
`include "soc_params.svh"

module system_registers import soc_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  bus_req_t             req,
    input  logic                 sel_leds,
    input  logic                 sel_bios,
    output bus_rsp_t             rsp,
    output logic [`NUM_LEDS-1:0] leds,
    output logic                 bios_enabled
);

    logic        ack;
    logic        wr_leds;
    logic        wr_bios;
    logic [15:0] rd_q;

    assign wr_leds = sel_leds && req.access && req.wr_en && req.bytesel[0] && !ack;
    assign wr_bios = sel_bios && req.access && req.wr_en && req.bytesel[0] && !ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack          <= 1'b0;
            leds         <= '0;
            bios_enabled <= 1'b1;
        end else begin
            ack <= (sel_leds || sel_bios) && req.access && !ack;
            if (wr_leds) begin
                leds <= req.wdata[`NUM_LEDS-1:0];
            end
            // Once cleared the shadow stays off until reset
            if (wr_bios) begin
                bios_enabled <= bios_enabled & req.wdata[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_q <= sel_leds ? 16'(leds) : {15'b0, bios_enabled};
    end

    assign rsp.rdata = ack ? rd_q : '0;
    assign rsp.ack   = ack;

endmodule

//--- rtl/interval_timer.sv
`include "soc_params.svh"

module interval_timer import soc_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  bus_req_t req,
    input  logic     sel,
    output bus_rsp_t rsp,
    output logic     timer_intr
);

    localparam int PRESCALE = `TIMER_PRESCALE;
    localparam int PW       = $clog2(PRESCALE + 1);

    logic [15:0]   reload;
    logic [15:0]   count;
    logic [PW-1:0] pre_cnt;
    logic          tick;
    logic          wr;
    logic          ack;
    logic [15:0]   rd_q;

    assign wr   = sel && req.access && req.wr_en && !ack;
    assign tick = (pre_cnt == PW'(PRESCALE - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            ack        <= 1'b0;
            reload     <= '0;
            count      <= '0;
            pre_cnt    <= '0;
            timer_intr <= 1'b0;
        end else begin
            ack        <= sel && req.access && !ack;
            timer_intr <= 1'b0;
            if (wr) begin
                reload  <= req.wdata;
                count   <= req.wdata;
                pre_cnt <= '0;      // Restart the prescaler
            end else if (reload != '0) begin
                pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
                if (tick) begin
                    if (count <= 16'd1) begin
                        count      <= reload;
                        timer_intr <= 1'b1;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_q <= count;
    end

    assign rsp.rdata = ack ? rd_q : '0;
    assign rsp.ack   = ack;

endmodule

//--- rtl/irq_controller.sv
module irq_controller import soc_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  bus_req_t   req,
    input  logic       sel,
    output bus_rsp_t   rsp,
    input  logic [7:0] intr_in,
    output logic       intr,
    output logic [2:0] irq_vector
);

    logic [7:0]  pending;
    logic [7:0]  mask;
    logic [7:0]  active;
    logic [7:0]  clear;
    logic        wr;
    logic        ack;
    logic [15:0] rd_q;

    // addr[1] picks the pending/vector port over the mask port
    assign wr    = sel && req.access && req.wr_en && !ack;
    assign clear = (wr && req.addr[1]) ? req.wdata[7:0] : 8'h00;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack     <= 1'b0;
            pending <= '0;
            mask    <= '0;
        end else begin
            ack     <= sel && req.access && !ack;
            pending <= (pending & ~clear) | intr_in;
            if (wr && !req.addr[1]) begin
                mask <= req.wdata[7:0];
            end
        end
    end

    assign active = pending & mask;
    assign intr   = |active;

    // Lowest pending line wins
    always_comb begin
        irq_vector = 3'd0;
        for (int i = 7; i >= 0; i--) begin
            if (active[i]) begin
                irq_vector = 3'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_q <= req.addr[1] ? {5'b0, irq_vector, pending} : {8'b0, mask};
    end

    assign rsp.rdata = ack ? rd_q : '0;
    assign rsp.ack   = ack;

endmodule

//--- rtl/soc_top.sv
`include "soc_params.svh"

module soc_top import soc_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  bus_req_t             data_req,
    input  logic                 d_io,
    output bus_rsp_t             data_rsp,
    input  bus_req_t             instr_req,
    output bus_rsp_t             instr_rsp,
    input  logic [7:1]           irq_lines,
    output logic [`NUM_LEDS-1:0] leds,
    output logic                 intr,
    output logic [2:0]           irq_vector
);

    bus_req_t data_mem_req;
    bus_req_t q_req;
    bus_rsp_t q_rsp;
    bus_rsp_t data_mem_rsp;
    bus_rsp_t io_rsp;
    bus_rsp_t main_rsp;
    bus_rsp_t bios_rsp;
    bus_rsp_t periph_rsp [4];
    io_sel_t  io_sel;
    logic     main_cs;
    logic     bios_cs;
    logic     bios_enabled;
    logic     timer_intr;

    always_comb begin
        data_mem_req        = data_req;
        data_mem_req.access = data_req.access & ~d_io;  // Memory cycles only
    end

    // Only one of the two sides can answer a given access
    assign data_rsp.rdata = io_rsp.rdata | data_mem_rsp.rdata;
    assign data_rsp.ack   = io_rsp.ack | data_mem_rsp.ack;

    assign periph_rsp[3] = '0;  // Spare I/O slot

    mem_arbiter u_mem_arbiter (
        .clk          (clk),
        .rst          (rst),
        .data_req     (data_mem_req),
        .instr_req    (instr_req),
        .q_rsp        (q_rsp),
        .q_req        (q_req),
        .data_mem_rsp (data_mem_rsp),
        .instr_rsp    (instr_rsp)
    );

    bus_decoder u_bus_decoder (
        .clk          (clk),
        .rst          (rst),
        .data_req     (data_req),
        .d_io         (d_io),
        .q_req        (q_req),
        .bios_enabled (bios_enabled),
        .main_rsp     (main_rsp),
        .bios_rsp     (bios_rsp),
        .periph_rsp   (periph_rsp),
        .io_sel       (io_sel),
        .main_cs      (main_cs),
        .bios_cs      (bios_cs),
        .q_rsp        (q_rsp),
        .io_rsp       (io_rsp)
    );

    onchip_ram #(.DEPTH(`MAIN_RAM_WORDS)) main_ram (
        .clk (clk),
        .rst (rst),
        .req (q_req),
        .cs  (main_cs),
        .rsp (main_rsp)
    );

    onchip_ram #(.DEPTH(`BIOS_RAM_WORDS)) bios_ram (
        .clk (clk),
        .rst (rst),
        .req (q_req),
        .cs  (bios_cs),
        .rsp (bios_rsp)
    );

    system_registers u_system_registers (
        .clk          (clk),
        .rst          (rst),
        .req          (data_req),
        .sel_leds     (io_sel.leds),
        .sel_bios     (io_sel.bios_ctrl),
        .rsp          (periph_rsp[0]),
        .leds         (leds),
        .bios_enabled (bios_enabled)
    );

    interval_timer u_interval_timer (
        .clk        (clk),
        .rst        (rst),
        .req        (data_req),
        .sel        (io_sel.timer),
        .rsp        (periph_rsp[1]),
        .timer_intr (timer_intr)
    );

    irq_controller u_irq_controller (
        .clk        (clk),
        .rst        (rst),
        .req        (data_req),
        .sel        (io_sel.irq),
        .rsp        (periph_rsp[2]),
        .intr_in    ({irq_lines, timer_intr}),
        .intr       (intr),
        .irq_vector (irq_vector)
    );

endmodule

//--- test/soc_tb.sv
`include "soc_params.svh"

module soc_tb import soc_pkg::*; ;
    timeunit 1ns;
    timeprecision 100ps;

    logic                 clk = 1'b0;
    logic                 rst;
    bus_req_t             data_req;
    bus_req_t             instr_req;
    logic                 d_io;
    bus_rsp_t             data_rsp;
    bus_rsp_t             instr_rsp;
    logic [7:1]           irq_lines;
    logic [`NUM_LEDS-1:0] leds;
    logic                 intr;
    logic [2:0]           irq_vector;

    logic [31:0] lfsr = 32'h1094_9ea8;
    logic [15:0] shadow [`MAIN_RAM_WORDS];     // Main RAM model
    int          errors;
    int          pass_count;
    int          fail_count;

    soc_top UUT (
        .clk        (clk),
        .rst        (rst),
        .data_req   (data_req),
        .d_io       (d_io),
        .data_rsp   (data_rsp),
        .instr_req  (instr_req),
        .instr_rsp  (instr_rsp),
        .irq_lines  (irq_lines),
        .leds       (leds),
        .intr       (intr),
        .irq_vector (irq_vector)
    );

    always #4 clk = ~clk;

    // Galois LFSR stepped once per bit
    function automatic logic [15:0] rand16();
        logic [15:0] v;
        for (int i = 0; i < 16; i++) begin
            v[i] = lfsr[0];
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    function automatic bus_req_t build_req(logic [19:0] a, logic [15:0] d, logic wr,
                                           logic [1:0] bs);
        bus_req_t r;
        r         = '0;
        r.addr    = a[19:1];
        r.wdata   = d;
        r.wr_en   = wr;
        r.bytesel = bs;
        r.access  = 1'b1;
        return r;
    endfunction

    task automatic check_rsp_data(input string name, input bus_rsp_t rsp, input logic [15:0] exp);
        if (rsp.rdata !== exp) begin
            $display("error: %s.rdata = %h, expected %h", name, rsp.rdata, exp);
            errors++;
        end
    endtask

    task automatic check_leds(input logic [`NUM_LEDS-1:0] exp);
        if (leds !== exp) begin
            $display("error: leds = %h, expected %h", leds, exp);
            errors++;
        end
    endtask

    task automatic check_irq_vector(input logic [2:0] exp);
        if (irq_vector !== exp) begin
            $display("error: irq_vector = %h, expected %h", irq_vector, exp);
            errors++;
        end
    endtask

    // Starts and ends 1 ns after a rising edge
    task automatic bus_access(input string bus, input logic [19:0] a, input logic [15:0] d,
                              input logic wr, input logic [1:0] bs, output bus_rsp_t rsp);
        int n;
        n = 0;
        if (bus == "i") begin
            instr_req = build_req(a, d, 1'b0, bs);
        end else begin
            data_req = build_req(a, d, wr, bs);
            d_io     = (bus == "io");
        end
        do begin
            @(posedge clk);
            #1;
            n++;
            rsp = (bus == "i") ? instr_rsp : data_rsp;
        end while (!rsp.ack && n < 50);
        if (!rsp.ack) begin
            $display("timeout: no ack on the %s bus for address %h", bus, a);
            errors++;
        end
        data_req  = '0;
        instr_req = '0;
        d_io      = 1'b0;
        @(posedge clk);     // Access stays low for a cycle
        #1;
    endtask

    task automatic watch_intr(input int cycles, input logic exp);
        int   n;
        logic seen;
        n    = 0;
        seen = intr;
        while (n < cycles && !(exp && seen)) begin
            @(posedge clk);
            #1;
            n++;
            seen = seen | intr;
        end
        if (seen !== exp) begin
            if (exp) begin
                $display("timeout: intr did not rise within %0d cycles", cycles);
            end else begin
                $display("error: intr = %h, expected %h", seen, exp);
            end
            errors++;
        end
    endtask

    task automatic ram_fill_test(input logic [19:0] base, input int count);
        logic [19:0] a;
        logic [15:0] d;
        logic [1:0]  bs;
        int          idx;
        bus_rsp_t    rsp;
        for (int i = 0; i < count; i++) begin
            a           = base + 20'(2 * i);
            d           = rand16();
            shadow[(a >> 1) % `MAIN_RAM_WORDS] = d;
            bus_access("d", a, d, 1'b1, 2'b11, rsp);
        end
        for (int i = 0; i < count; i++) begin
            a   = base + 20'(2 * i);
            idx = int'(a >> 1) % `MAIN_RAM_WORDS;
            bus_access("d", a, '0, 1'b0, 2'b11, rsp);
            check_rsp_data("data_rsp", rsp, shadow[idx]);
            bus_access("i", a, '0, 1'b0, 2'b11, rsp);
            check_rsp_data("instr_rsp", rsp, shadow[idx]);
            bs = i[0] ? 2'b10 : 2'b01;     // Alternate low and high byte
            d  = rand16();
            if (bs[0]) begin
                shadow[idx][7:0] = d[7:0];
            end
            if (bs[1]) begin
                shadow[idx][15:8] = d[15:8];
            end
            bus_access("d", a, d, 1'b1, bs, rsp);
            bus_access("d", a, '0, 1'b0, 2'b11, rsp);
            check_rsp_data("data_rsp", rsp, shadow[idx]);
        end
    endtask

    task automatic arbitration_test(input logic [19:0] a, input logic [15:0] exp);
        int d_at;
        int i_at;
        int n;
        d_at      = 0;
        i_at      = 0;
        n         = 0;
        data_req  = build_req(a, '0, 1'b0, 2'b11);
        instr_req = build_req(a, '0, 1'b0, 2'b11);
        d_io      = 1'b0;
        while ((d_at == 0 || i_at == 0) && n < 50) begin
            @(posedge clk);
            #1;
            n++;
            if (d_at == 0 && data_rsp.ack) begin
                check_rsp_data("data_rsp", data_rsp, exp);
                d_at     = n;
                data_req = '0;
            end
            if (i_at == 0 && instr_rsp.ack) begin
                check_rsp_data("instr_rsp", instr_rsp, exp);
                i_at      = n;
                instr_req = '0;
            end
        end
        if (d_at == 0 || i_at == 0) begin
            $display("timeout: both buses requested but not both acked");
            errors++;
        end else if (d_at > i_at) begin
            $display("data ack in cycle %0d came after instruction ack in %0d", d_at, i_at);
            errors++;
        end
        data_req  = '0;
        instr_req = '0;
        @(posedge clk);
        #1;
    endtask

    initial begin
        string       line;
        string       op;
        string       bus;
        logic [19:0] addr;
        logic [15:0] wdata;
        logic [1:0]  bytesel;
        logic [15:0] exp;
        bus_rsp_t    rsp;
        int          fd;
        int          test_no;
        rst        = 1'b1;
        data_req   = '0;
        instr_req  = '0;
        d_io       = 1'b0;
        irq_lines  = '0;
        pass_count = 0;
        fail_count = 0;
        test_no    = 0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;
        fd = $fopen("test/soc_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open test/soc_vectors.txt");
            fail_count++;
        end
        while (fd != 0 && $fgets(line, fd) != 0) begin
            if (line[0] == "#" || $sscanf(line, "%s %s %h %h %h %h", op, bus, addr, wdata,
                                          bytesel, exp) != 6) begin
                continue;   // Comment or blank line
            end
            errors = 0;
            test_no++;
            case (op)
                "fill":  ram_fill_test(addr, int'(wdata));
                "wr":    bus_access(bus, addr, wdata, 1'b1, bytesel, rsp);
                "rd": begin
                    bus_access(bus, addr, '0, 1'b0, bytesel, rsp);
                    check_rsp_data(bus == "i" ? "instr_rsp" : "data_rsp", rsp, exp);
                end
                "leds":  check_leds(exp[`NUM_LEDS-1:0]);
                "arb":   arbitration_test(addr, exp);
                "timer": begin
                    bus_access("io", 20'(`TIMER_PORT), wdata, 1'b1, 2'b11, rsp);
                    watch_intr(int'(wdata) * `TIMER_PRESCALE + 4, 1'b1);
                end
                "intr":  watch_intr(int'(wdata), exp[0]);
                "vec":   check_irq_vector(exp[2:0]);
                "pulse": begin
                    irq_lines = wdata[7:1];
                    @(posedge clk);
                    #1;
                    irq_lines = '0;
                end
                default: begin
                    $display("unknown operation %s in the vector file", op);
                    errors++;
                end
            endcase
            if (errors == 0) begin
                pass_count++;
                $display("test %0d %s: ok", test_no, op);
            end else begin
                fail_count++;
                $display("test %0d %s: failed with %0d errors", test_no, op, errors);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        $display("tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && pass_count > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+rtl
rtl/soc_pkg.sv
rtl/mem_arbiter.sv
rtl/bus_decoder.sv
rtl/onchip_ram.sv
rtl/system_registers.sv
rtl/interval_timer.sv
rtl/irq_controller.sv
rtl/soc_top.sv
test/soc_tb.sv

//--- test/soc_vectors.txt
# op bus addr wdata bytesel expected, all hex; bus d = data memory, i = instruction, io = port
# fill takes a word count in wdata, timer a reload value, intr a cycle count, pulse the lines
fill  d  00100 0010 3 0000
wr    d  00200 1234 3 0000
wr    d  00200 abcd 1 0000
rd    d  00200 0000 3 12cd
rd    i  00200 0000 3 12cd
wr    d  00000 1111 3 0000
wr    d  fc000 beef 3 0000
rd    d  fc000 0000 3 beef
rd    i  fc000 0000 3 beef
rd    d  00000 0000 3 1111
wr    io ffec 0000 1 0000
rd    io ffec 0000 3 0000
rd    d  fc000 0000 3 1111
wr    io fffe 00a5 1 0000
leds  -  0 0000 0 00a5
rd    io fffe 0000 3 00a5
wr    d  01234 5a5a 3 0000
wr    io 1234 ffff 3 0000
rd    io 1234 0000 3 0000
rd    d  01234 0000 3 5a5a
arb   d  00200 0000 3 12cd
wr    io fff4 0001 1 0000
timer -  0 000a 0 0000
vec   -  0 0000 0 0000
wr    io fff6 0001 1 0000
intr  -  0 0002 0 0000
wr    io ffee 0000 3 0000
wr    io fff4 0028 1 0000
pulse -  0 0028 0 0000
intr  -  0 0004 0 0001
vec   -  0 0000 0 0003
rd    io fff6 0000 3 0328
wr    io fff6 0008 1 0000
vec   -  0 0000 0 0005
wr    io fff6 0020 1 0000
pulse -  0 0004 0 0000
intr  -  0 0014 0 0000
